//--- vlog.f
src/addrgen_cfg_pkg.sv
src/addrgen_types_pkg.sv
src/burst_cmd_if.sv
src/addrgen_ctrl.sv
src/burst_engine.sv
src/credit_counter.sv
src/addrgen_top.sv
tests/addrgen_props.sv
tests/tb_addrgen.sv

//--- Makefile
# Verilator flow for the vector address generator testbench

VERILATOR ?= verilator
TOP       ?= tb_addrgen
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator's own status is not trusted
run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/tb_addrgen.sv
module tb_addrgen;

  timeunit 1ns;
  timeprecision 1ps;

  import addrgen_cfg_pkg::*;
  import addrgen_types_pkg::*;

  localparam int unsigned ClkPeriod   = 20;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned NumRequests = 34;
  // Long strided requests under withheld credits dominate
  localparam int unsigned WorstCycles = 3000;
  localparam int unsigned TimeoutNs   = (ResetCycles + NumRequests * WorstCycles) * ClkPeriod;

  // Expected bus request and the channel it belongs on
  typedef struct packed {
    ax_req_t ax;
    logic    is_load;
  } exp_t;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       req_valid_i;
  logic       req_ready_o;
  addr_t      req_addr_i;
  len_t       req_len_i;
  addr_t      req_stride_i;
  vew_e       req_vew_i;
  logic       req_is_load_i;
  logic       req_unit_stride_i;
  logic       ack_o;
  logic       error_o;
  addr_t      ar_addr_o;
  logic [7:0] ar_len_o;
  logic [2:0] ar_size_o;
  logic       ar_valid_o;
  logic       ar_ready_i = 1'b0;
  addr_t      aw_addr_o;
  logic [7:0] aw_len_o;
  logic [2:0] aw_size_o;
  logic       aw_valid_o;
  logic       aw_ready_i = 1'b0;
  logic       cmd_valid_o;
  addr_t      cmd_addr_o;
  logic [7:0] cmd_len_o;
  logic [2:0] cmd_size_o;
  logic       cmd_is_load_o;
  logic       cmd_credit_i = 1'b0;

  exp_t        exp_q[$];
  // Cycle in which each outstanding credit goes back
  int unsigned due_q[$];
  int unsigned cycle        = 0;
  int unsigned credit_delay = 4;
  int unsigned checks       = 0;
  int unsigned errors       = 0;
  int unsigned acks         = 0;
  int unsigned issued       = 0;
  int unsigned returned     = 0;
  int unsigned requests     = 0;
  int unsigned bursts       = 0;

  addrgen_top dut0 (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Compare one value and report a mismatch
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Expected bus requests of one request, in issue order
  function automatic void build_expected(input mem_req_t r);
    longint unsigned addr;
    longint unsigned first;
    longint unsigned last;
    longint unsigned span;
    longint unsigned esize;
    longint unsigned consumed;
    int unsigned     rem;
    int unsigned     i;
    exp_t            e;
    esize     = 64'd1 << r.vew;
    rem       = 32'(r.len);
    e.is_load = r.is_load;
    // Misaligned base never reaches the bus
    if ((64'(r.addr) & (esize - 64'd1)) != 64'd0) begin
      return;
    end
    if (r.unit_stride) begin
      addr = 64'(r.addr);
      while (rem > 0) begin
        first = addr & ~64'd7;
        // At most 256 beats of 8 bytes
        span = 64'(rem) * esize;
        if (span > 64'd2048) begin
          span = 64'd2048;
        end
        last = ((addr + span - 64'd1) & ~64'd7) + 64'd7;
        // Stay inside the 4 KiB page of the first byte
        if (last > (addr | 64'hFFF)) begin
          last = addr | 64'hFFF;
        end
        e.ax.addr = 32'(addr);
        e.ax.len  = 8'((last - first) / 64'd8);
        e.ax.size = 3'd3;
        exp_q.push_back(e);
        consumed = (last - addr + 64'd1) / esize;
        rem      = (consumed >= 64'(rem)) ? 0 : rem - 32'(consumed);
        addr     = last + 64'd1;
      end
    end else begin
      for (i = 0; i < rem; i++) begin
        e.ax.addr = r.addr + i * r.stride;
        e.ax.len  = 8'd0;
        e.ax.size = {1'b0, r.vew};
        exp_q.push_back(e);
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus and load/store unit models
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    ar_ready_i <= ($urandom % 4) != 0;
    aw_ready_i <= ($urandom % 4) != 0;
  end

  // Consumer hands back one credit per cycle once it is due
  always @(posedge clk_i) begin
    cycle++;
    if (due_q.size() != 0 && due_q[0] <= cycle) begin
      cmd_credit_i <= 1'b1;
      void'(due_q.pop_front());
    end else begin
      cmd_credit_i <= 1'b0;
    end
  end

  // Outputs are stable mid-cycle, a handshake here completes on the next edge
  always @(negedge clk_i) begin
    exp_t    e;
    ax_req_t got;
    logic    hs_ar;
    logic    hs_aw;
    string   ch;
    if (rst_ni) begin
      hs_ar = ar_valid_o && ar_ready_i;
      hs_aw = aw_valid_o && aw_ready_i;
      ch    = hs_ar ? "ar" : "aw";
      got   = hs_ar ? ax_req_t'({ar_addr_o, ar_len_o, ar_size_o}) :
                      ax_req_t'({aw_addr_o, aw_len_o, aw_size_o});
      if (hs_ar || hs_aw) begin
        bursts++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("error: %0t bus request at 0x%0h was not expected", $time, got.addr);
        end else begin
          e = exp_q.pop_front();
          check_value("channel_is_ar", 64'(hs_ar), 64'(e.is_load));
          check_value({ch, "_addr_o"}, 64'(got.addr), 64'(e.ax.addr));
          check_value({ch, "_len_o"}, 64'(got.len), 64'(e.ax.len));
          check_value({ch, "_size_o"}, 64'(got.size), 64'(e.ax.size));
        end
        // Command mirrors the handshake field by field
        check_value("cmd_valid_o", 64'(cmd_valid_o), 64'd1);
        check_value("cmd_addr_o", 64'(cmd_addr_o), 64'(got.addr));
        check_value("cmd_len_o", 64'(cmd_len_o), 64'(got.len));
        check_value("cmd_size_o", 64'(cmd_size_o), 64'(got.size));
        check_value("cmd_is_load_o", 64'(cmd_is_load_o), 64'(hs_ar));
      end else if (cmd_valid_o) begin
        check_value("cmd_valid_o", 64'(cmd_valid_o), 64'd0);
      end
      if (cmd_valid_o) begin
        issued++;
        due_q.push_back(cycle + 1 + ($urandom % credit_delay));
      end
      if (cmd_credit_i) begin
        returned++;
      end
      if (issued - returned > CmdCredits) begin
        errors++;
        $display("error: %0t more than %0d commands outstanding", $time, CmdCredits);
      end
      if (ack_o) begin
        acks++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // One request from handshake to ack
  task automatic run_request(input addr_t addr, input len_t len, input addr_t stride,
                             input logic [1:0] vew, input logic is_load,
                             input logic unit_stride);
    mem_req_t r;
    logic     misaligned;
    r.addr        = addr;
    r.len         = len;
    r.stride      = stride;
    r.vew         = vew_e'(vew);
    r.is_load     = is_load;
    r.unit_stride = unit_stride;
    misaligned    = (addr & ((32'd1 << vew) - 32'd1)) != 32'd0;
    bursts        = 0;
    build_expected(r);
    @(posedge clk_i);
    req_valid_i       <= 1'b1;
    req_addr_i        <= addr;
    req_len_i         <= len;
    req_stride_i      <= stride;
    req_vew_i         <= vew_e'(vew);
    req_is_load_i     <= is_load;
    req_unit_stride_i <= unit_stride;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    do @(negedge clk_i); while (!ack_o);
    check_value("error_o", 64'(error_o), 64'(misaligned));
    // Every expected burst must have gone out by the ack
    @(posedge clk_i);
    check_value("pending_bursts", 64'(exp_q.size()), 64'd0);
    exp_q.delete();
    requests++;
  endtask

  initial begin
    void'($urandom(63839));
    rst_ni            <= 1'b0;
    req_valid_i       <= 1'b0;
    req_addr_i        <= '0;
    req_len_i         <= '0;
    req_stride_i      <= '0;
    req_vew_i         <= VEW8;
    req_is_load_i     <= 1'b0;
    req_unit_stride_i <= 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Idle outputs after reset
    @(negedge clk_i);
    check_value("req_ready_o", 64'(req_ready_o), 64'd1);
    check_value("ar_valid_o", 64'(ar_valid_o), 64'd0);
    check_value("aw_valid_o", 64'(aw_valid_o), 64'd0);
    check_value("cmd_valid_o", 64'(cmd_valid_o), 64'd0);
    check_value("ack_o", 64'(ack_o), 64'd0);
    check_value("error_o", 64'(error_o), 64'd0);

    // 600 doublewords split into 256, 256 and 88 beats
    run_request(32'h0001_0000, 16'd600, 32'd0, 2'd3, 1'b1, 1'b1);
    check_value("burst_count", 64'(bursts), 64'd3);

    // Stores across 4 KiB boundaries
    run_request(32'h0002_0F00, 16'd100, 32'd0, 2'd3, 1'b0, 1'b1);
    run_request(32'h0003_FFF4, 16'd50, 32'd0, 2'd2, 1'b0, 1'b1);
    run_request(32'h0004_0FFE, 16'd2000, 32'd0, 2'd1, 1'b0, 1'b1);

    // Strided loads with random width and stride
    repeat (8) begin
      run_request($urandom & 32'h00FF_FFF8, len_t'(1 + $urandom % 16),
                  32'($urandom % 512), 2'($urandom % 4), 1'b1, 1'b0);
    end

    // Misaligned bases
    run_request(32'h0000_1001, 16'd4, 32'd0, 2'd1, 1'b1, 1'b1);
    run_request(32'h0000_2004, 16'd4, 32'd8, 2'd3, 1'b0, 1'b0);

    // Slow credit return under random ready
    credit_delay = 40;
    repeat (20) begin
      if (($urandom % 2) != 0) begin
        run_request($urandom & 32'h000F_FFF8, len_t'(1 + $urandom % 700), 32'd0,
                    2'($urandom % 4), 1'($urandom % 2), 1'b1);
      end else begin
        run_request($urandom & 32'h000F_FFF8, len_t'(1 + $urandom % 48),
                    32'($urandom % 128), 2'($urandom % 4), 1'($urandom % 2), 1'b0);
      end
    end

    check_value("ack_count", 64'(acks), 64'(requests));
    // Failed assertions in the bound checker count as errors
    errors += dut0.props0.failures;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("error: %0t watchdog expired before all requests were acknowledged", $time);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- tests/addrgen_props.sv
module addrgen_props (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ar_valid_i,
  input  logic                       ar_ready_i,
  input  addrgen_types_pkg::ax_req_t ar_i,
  input  logic                       aw_valid_i,
  input  logic                       aw_ready_i,
  input  addrgen_types_pkg::ax_req_t aw_i,
  input  logic                       cmd_valid_i,
  input  logic                       credit_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import addrgen_cfg_pkg::*;

  logic        handshake;
  // Commands sent minus credits returned
  logic [3:0]  outstanding_q;
  // Number of failed assertions
  int unsigned failures = 0;

  assign handshake = (ar_valid_i && ar_ready_i) || (aw_valid_i && aw_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 4'(cmd_valid_i) - 4'(credit_i);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and credit rules
  ////////////////////////////////////////////////////////////////////////////

  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else begin
      failures++;
      $error("AR request dropped or changed before ready");
    end

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else begin
      failures++;
      $error("AW request dropped or changed before ready");
    end

  // One command exactly in each handshake cycle
  cmd_with_handshake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i == handshake)
    else begin
      failures++;
      $error("command does not line up with a bus handshake");
    end

  credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    outstanding_q <= 4'(CmdCredits))
    else begin
      failures++;
      $error("more commands outstanding than credits");
    end

endmodule

bind addrgen_top addrgen_props props0 (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .ar_valid_i  (ar_valid_o),
  .ar_ready_i  (ar_ready_i),
  .ar_i        (ar),
  .aw_valid_i  (aw_valid_o),
  .aw_ready_i  (aw_ready_i),
  .aw_i        (aw),
  .cmd_valid_i (cmd_valid_o),
  .credit_i    (cmd_credit_i)
);

//--- src/addrgen_top.sv
module addrgen_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Vector memory request
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  addrgen_cfg_pkg::addr_t   req_addr_i,
  input  addrgen_cfg_pkg::len_t    req_len_i,
  input  addrgen_cfg_pkg::addr_t   req_stride_i,
  input  addrgen_types_pkg::vew_e  req_vew_i,
  input  logic                     req_is_load_i,
  input  logic                     req_unit_stride_i,
  // Completion
  output logic                     ack_o,
  output logic                     error_o,
  // Read address channel
  output addrgen_cfg_pkg::addr_t   ar_addr_o,
  output logic [7:0]               ar_len_o,
  output logic [2:0]               ar_size_o,
  output logic                     ar_valid_o,
  input  logic                     ar_ready_i,
  // Write address channel
  output addrgen_cfg_pkg::addr_t   aw_addr_o,
  output logic [7:0]               aw_len_o,
  output logic [2:0]               aw_size_o,
  output logic                     aw_valid_o,
  input  logic                     aw_ready_i,
  // Load/store command stream
  output logic                     cmd_valid_o,
  output addrgen_cfg_pkg::addr_t   cmd_addr_o,
  output logic [7:0]               cmd_len_o,
  output logic [2:0]               cmd_size_o,
  output logic                     cmd_is_load_o,
  input  logic                     cmd_credit_i
);

  import addrgen_types_pkg::*;

  mem_req_t req;
  ax_req_t  ar;
  ax_req_t  aw;
  ax_req_t  cmd;
  logic     has_credit;
  logic     issue;

  burst_cmd_if burst_if ();

  // Pack the request fields
  assign req = '{
    addr:        req_addr_i,
    len:         req_len_i,
    stride:      req_stride_i,
    vew:         req_vew_i,
    is_load:     req_is_load_i,
    unit_stride: req_unit_stride_i
  };

  addrgen_ctrl i_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_i       (req),
    .req_ready_o (req_ready_o),
    .ack_o       (ack_o),
    .error_o     (error_o),
    .burst       (burst_if.ctrl_mp)
  );

  burst_engine i_engine (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .burst         (burst_if.engine_mp),
    .has_credit_i  (has_credit),
    .issue_o       (issue),
    .ar_o          (ar),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .aw_o          (aw),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .cmd_o         (cmd),
    .cmd_is_load_o (cmd_is_load_o)
  );

  credit_counter i_credits (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .credit_i     (cmd_credit_i),
    .has_credit_o (has_credit)
  );

  // Unpack onto the bus ports
  assign ar_addr_o  = ar.addr;
  assign ar_len_o   = ar.len;
  assign ar_size_o  = ar.size;
  assign aw_addr_o  = aw.addr;
  assign aw_len_o   = aw.len;
  assign aw_size_o  = aw.size;

  // Command goes out in the handshake cycle
  assign cmd_valid_o = issue;
  assign cmd_addr_o  = cmd.addr;
  assign cmd_len_o   = cmd.len;
  assign cmd_size_o  = cmd.size;

endmodule

//--- src/credit_counter.sv
module credit_counter (
  input  logic clk_i,
  input  logic rst_ni,
  // Command sent to the load/store units
  input  logic issue_i,
  // Credit returned by the load/store units
  input  logic credit_i,
  output logic has_credit_o
);

  import addrgen_cfg_pkg::*;

  typedef logic [$clog2(CmdCredits + 1)-1:0] cnt_t;

  cnt_t cnt_q;

  ////////////////////////////////////////////////////////////////////////////
  // Credit count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // All credits available out of reset
      cnt_q <= cnt_t'(CmdCredits);
    end else begin
      case ({issue_i, credit_i})
        2'b10: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - cnt_t'(1);
          end
        end
        2'b01: begin
          // Never above the reset value
          if (cnt_q != cnt_t'(CmdCredits)) begin
            cnt_q <= cnt_q + cnt_t'(1);
          end
        end
        // Issue and return together cancel out
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign has_credit_o = (cnt_q != '0);

endmodule

//--- src/burst_engine.sv
module burst_engine (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Controller
  burst_cmd_if.engine_mp             burst,
  // Command credits
  input  logic                       has_credit_i,
  output logic                       issue_o,
  // Read address channel
  output addrgen_types_pkg::ax_req_t ar_o,
  output logic                       ar_valid_o,
  input  logic                       ar_ready_i,
  // Write address channel
  output addrgen_types_pkg::ax_req_t aw_o,
  output logic                       aw_valid_o,
  input  logic                       aw_ready_i,
  // Load/store command fields
  output addrgen_types_pkg::ax_req_t cmd_o,
  output logic                       cmd_is_load_o
);

  import addrgen_cfg_pkg::*;
  import addrgen_types_pkg::*;

  typedef enum logic [1:0] {
    E_IDLE,
    E_SETUP,
    E_REQ
  } state_e;

  state_e   state_q, state_d;
  // Address and len fields move as bus requests go out
  mem_req_t req_q, req_d;
  // Bus-aligned first byte and last byte of the current burst
  addr_t    start_q, start_d;
  addr_t    end_q, end_d;

  ax_req_t  ax;
  logic     ax_valid;
  logic     ax_ready;
  logic     handshake;
  addr_t    consumed;
  len_t     uni_len_next;

  // Round down to a bus word
  function automatic addr_t align_bus(addr_t a);
    return {a[AddrWidth-1:BusSizeLog], {BusSizeLog{1'b0}}};
  endfunction

  // Last byte of a burst starting at addr with len elements left
  function automatic addr_t burst_end(addr_t addr, len_t len, vew_e vew);
    addr_t bytes;
    addr_t span;
    addr_t last;
    bytes = addr_t'(len) << vew;
    span  = (bytes > addr_t'(MaxBurstBeats * BusBytes)) ?
            addr_t'(MaxBurstBeats * BusBytes) : bytes;
    last  = align_bus(addr + span - addr_t'(1)) + addr_t'(BusBytes - 1);
    // Clip at the end of the start page
    if (last[AddrWidth-1:PageBits] != addr[AddrWidth-1:PageBits]) begin
      last = {addr[AddrWidth-1:PageBits], {PageBits{1'b1}}};
    end
    return last;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ax.addr = req_q.addr;
    if (req_q.unit_stride) begin
      ax.len  = 8'((end_q - start_q) >> BusSizeLog);
      ax.size = 3'(BusSizeLog);
    end else begin
      // One element per single-beat request
      ax.len  = '0;
      ax.size = 3'(req_q.vew);
    end
  end

  // No valid without a credit; credits only drop on a handshake,
  // so valid holds once raised
  assign ax_valid   = (state_q == E_REQ) && has_credit_i;
  assign ax_ready   = req_q.is_load ? ar_ready_i : aw_ready_i;
  assign handshake  = ax_valid && ax_ready;

  assign ar_o       = ax;
  assign aw_o       = ax;
  assign ar_valid_o = ax_valid && req_q.is_load;
  assign aw_valid_o = ax_valid && !req_q.is_load;

  // Command mirrors the handshake
  assign issue_o       = handshake;
  assign cmd_o         = ax;
  assign cmd_is_load_o = req_q.is_load;

  // Elements covered by this burst, saturated at what is left
  assign consumed     = (end_q - req_q.addr + addr_t'(1)) >> req_q.vew;
  assign uni_len_next = (consumed >= addr_t'(req_q.len)) ?
                        '0 : req_q.len - len_t'(consumed);

  ////////////////////////////////////////////////////////////////////////////
  // Engine FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    req_d      = req_q;
    start_d    = start_q;
    end_d      = end_q;
    burst.done = 1'b0;

    case (state_q)
      E_IDLE: begin
        if (burst.start) begin
          req_d   = burst.req;
          state_d = E_SETUP;
        end
      end
      E_SETUP: begin
        start_d = align_bus(req_q.addr);
        end_d   = burst_end(req_q.addr, req_q.len, req_q.vew);
        // Empty request has nothing to send
        if (req_q.len == '0) begin
          burst.done = 1'b1;
          state_d    = E_IDLE;
        end else begin
          state_d = E_REQ;
        end
      end
      E_REQ: begin
        if (handshake) begin
          if (req_q.unit_stride) begin
            req_d.addr = end_q + addr_t'(1);
            req_d.len  = uni_len_next;
            // Next burst bounds ready for the following cycle
            start_d    = align_bus(req_d.addr);
            end_d      = burst_end(req_d.addr, req_d.len, req_q.vew);
          end else begin
            req_d.addr = req_q.addr + req_q.stride;
            req_d.len  = req_q.len - len_t'(1);
          end
          if (req_d.len == '0) begin
            burst.done = 1'b1;
            state_d    = E_IDLE;
          end
        end
      end
      default: state_d = E_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= E_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q   <= req_d;
    start_q <= start_d;
    end_q   <= end_d;
  end

endmodule

//--- src/addrgen_ctrl.sv
module addrgen_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Request handshake
  input  logic                        req_valid_i,
  input  addrgen_types_pkg::mem_req_t req_i,
  output logic                        req_ready_o,
  // Completion
  output logic                        ack_o,
  output logic                        error_o,
  // Burst engine
  burst_cmd_if.ctrl_mp                burst
);

  import addrgen_cfg_pkg::*;
  import addrgen_types_pkg::*;

  // IDLE waits for a request, CHECK tests alignment, BUSY waits for the engine
  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    BUSY
  } state_e;

  state_e   state_q, state_d;
  mem_req_t req_q;
  addr_t    align_mask;
  logic     misaligned;

  ////////////////////////////////////////////////////////////////////////////
  // Alignment check
  ////////////////////////////////////////////////////////////////////////////

  // Low address bits below the element size must be zero
  assign align_mask = (addr_t'(1) << req_q.vew) - addr_t'(1);
  assign misaligned = |(req_q.addr & align_mask);

  ////////////////////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////////////////////

  assign req_ready_o = (state_q == IDLE);
  assign burst.req   = req_q;

  always_comb begin
    state_d     = state_q;
    ack_o       = 1'b0;
    error_o     = 1'b0;
    burst.start = 1'b0;

    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        if (misaligned) begin
          // Finish at once, nothing reaches the bus
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = IDLE;
        end else begin
          burst.start = 1'b1;
          state_d     = BUSY;
        end
      end
      BUSY: begin
        // Ack goes out with the last bus handshake
        if (burst.done) begin
          ack_o   = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request fields captured on the handshake
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

endmodule

//--- src/burst_cmd_if.sv
interface burst_cmd_if;

  import addrgen_types_pkg::*;

  // One-cycle pulse, only while the engine is idle
  logic     start;

  // Request fields, valid with start
  mem_req_t req;

  // One-cycle pulse on the last bus handshake
  logic     done;

  // Controller side
  modport ctrl_mp (
    output start,
    output req,
    input  done
  );

  // Burst engine side
  modport engine_mp (
    input  start,
    input  req,
    output done
  );

endinterface

//--- src/addrgen_types_pkg.sv
package addrgen_types_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Element width
  ////////////////////////////////////////////////////////////////////////////

  // Encoded as log2 of the element size in bytes,
  // so it doubles as the size code of a single-beat request
  typedef enum logic [1:0] {
    VEW8  = 2'd0,
    VEW16 = 2'd1,
    VEW32 = 2'd2,
    VEW64 = 2'd3
  } vew_e;

  ////////////////////////////////////////////////////////////////////////////
  // Vector memory request
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    addrgen_cfg_pkg::addr_t addr;
    addrgen_cfg_pkg::len_t  len;
    // Byte distance between elements, strided only
    addrgen_cfg_pkg::addr_t stride;
    vew_e                   vew;
    logic                   is_load;
    // Unit-stride requests become incrementing bursts
    logic                   unit_stride;
  } mem_req_t;

  ////////////////////////////////////////////////////////////////////////////
  // Bus request, also sent as load/store command
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    addrgen_cfg_pkg::addr_t addr;
    // Beat count minus one
    logic [7:0]             len;
    // log2 of bytes per beat
    logic [2:0]             size;
  } ax_req_t;

endpackage

//--- src/addrgen_cfg_pkg.sv
package addrgen_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////////////////////

  // Byte address width
  localparam int unsigned AddrWidth = 32;

  // Data bus is 64 bits wide
  localparam int unsigned BusBytes   = 8;
  localparam int unsigned BusSizeLog = 3;

  // Incrementing bursts stop at 256 beats and never leave a 4 KiB page
  localparam int unsigned MaxBurstBeats = 256;
  localparam int unsigned PageBits      = 12;

  ////////////////////////////////////////////////////////////////////////////
  // Request and command stream
  ////////////////////////////////////////////////////////////////////////////

  // Element count of one vector request
  localparam int unsigned LenWidth = 16;

  // Commands the load/store units can take before returning a credit
  localparam int unsigned CmdCredits = 2;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [LenWidth-1:0]  len_t;

endpackage
